// File: sim.f
+incdir+include
verilog/command_pkg.sv
verilog/spi_peripheral.sv
verilog/spi_register.sv
verilog/palette_registers.sv
verilog/spi_command_top.sv
bench/spi_command_assertions.sv
bench/spi_command_tb.sv

// File: Bender.yml
package:
  name: spi_command

export_include_dirs:
  - include

sources:
  - files:
      - verilog/command_pkg.sv
      - verilog/spi_peripheral.sv
      - verilog/spi_register.sv
      - verilog/palette_registers.sv
      - verilog/spi_command_top.sv
  - target: test
    files:
      - bench/spi_command_assertions.sv
      - bench/spi_command_tb.sv

// File: bench/spi_command_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "command_consts.svh"

module spi_command_tb;

localparam int HALF_BIT_CYCLES = 8;
// About 240 bytes of 128 cycles each plus select gaps and margin
localparam int TIMEOUT_CYCLES = 40000;

logic clock;
logic reset;
logic spi_select;
logic spi_clock;
logic spi_data_in;
logic spi_data_out;

int error_count = 0;
int cycle_count = 0;
logic [31:0] lcg_state = 32'd21277;

logic [7:0] tx_bytes [8];
logic [7:0] rx_bytes [8];
logic [7:0] model_y [`PALETTE_DEPTH];
logic [7:0] model_cb [`PALETTE_DEPTH];
logic [7:0] model_cr [`PALETTE_DEPTH];

spi_command_top i_dut (
    .clock(clock),
    .reset(reset),
    .spi_select(spi_select),
    .spi_clock(spi_clock),
    .spi_data_in(spi_data_in),
    .spi_data_out(spi_data_out)
);

initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
end

initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
        @(posedge clock);
        cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
end

function automatic logic [7:0] random_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
endfunction

task automatic check_byte(input string name, input logic [7:0] expected,
                          input logic [7:0] actual);
    if (actual !== expected) begin
        $display("error %s: expected %h, got %h", name, expected, actual);
        error_count++;
    end
endtask

task automatic check_opcode(input command_pkg::opcode_e expected,
                            input command_pkg::opcode_e actual);
    if (actual !== expected) begin
        $display("error opcode: expected %h, got %h", expected, actual);
        error_count++;
    end
endtask

// Mode 0 bit shifting with data changing while spi_clock is low
task automatic shift_bits(input logic [7:0] data, input int bits,
                          output logic [7:0] collected);
    collected = 8'h00;
    for (int i = 7; i > 7 - bits; i--) begin
        spi_data_in <= data[i];
        repeat (HALF_BIT_CYCLES) @(posedge clock);
        collected[i] = spi_data_out;    // Value at the rising edge
        spi_clock <= 1'b1;
        repeat (HALF_BIT_CYCLES) @(posedge clock);
        spi_clock <= 1'b0;
    end
endtask

task automatic spi_transfer_byte(input logic [7:0] data, output logic [7:0] collected);
    shift_bits(data, 8, collected);
endtask

task automatic start_transaction();
    spi_select <= 1'b0;
    repeat (HALF_BIT_CYCLES) @(posedge clock);
endtask

task automatic end_transaction();
    repeat (HALF_BIT_CYCLES) @(posedge clock);
    spi_select <= 1'b1;
    spi_data_in <= 1'b0;
    repeat (HALF_BIT_CYCLES) @(posedge clock);
endtask

task automatic run_transaction(input int count);
    start_transaction();
    for (int i = 0; i < count; i++) begin
        spi_transfer_byte(tx_bytes[i], rx_bytes[i]);
        if (i == 0)
            check_opcode(command_pkg::opcode_e'(tx_bytes[0]),
                         i_dut.spi_peripheral.i_assertions.opcode);
    end
    end_transaction();
endtask

task automatic write_entry(input logic [3:0] index, input logic [7:0] y,
                           input logic [7:0] cb, input logic [7:0] cr);
    tx_bytes[0] = command_pkg::PALETTE_WRITE;
    tx_bytes[1] = {4'h0, index};
    tx_bytes[2] = y;
    tx_bytes[3] = cb;
    tx_bytes[4] = cr;
    run_transaction(5);
    for (int i = 0; i < 5; i++) check_byte("write response", 8'h00, rx_bytes[i]);
    model_y[index] = y;
    model_cb[index] = cb;
    model_cr[index] = cr;
endtask

task automatic read_entry(input logic [3:0] index);
    tx_bytes[0] = command_pkg::PALETTE_READ;
    tx_bytes[1] = {4'h0, index};
    for (int i = 2; i < 5; i++) tx_bytes[i] = 8'h00;
    run_transaction(5);
    check_byte("read opcode byte", 8'h00, rx_bytes[0]);
    check_byte("read index byte", 8'h00, rx_bytes[1]);
    check_byte("palette_y", model_y[index], rx_bytes[2]);
    check_byte("palette_cb", model_cb[index], rx_bytes[3]);
    check_byte("palette_cr", model_cr[index], rx_bytes[4]);
endtask

task automatic check_chip_id();
    tx_bytes[0] = command_pkg::CHIP_ID;
    tx_bytes[1] = 8'h00;
    tx_bytes[2] = 8'h00;
    run_transaction(3);
    check_byte("chip opcode byte", 8'h00, rx_bytes[0]);
    check_byte("chip_id", 8'h81, rx_bytes[1]);
    check_byte("chip second dummy", 8'h00, rx_bytes[2]);
endtask

// Stops after Cb or partway into Cr
task automatic abort_write(input logic [3:0] index, input int partial_bits);
    logic [7:0] discard;
    start_transaction();
    spi_transfer_byte(command_pkg::PALETTE_WRITE, discard);
    spi_transfer_byte({4'h0, index}, discard);
    spi_transfer_byte(8'hEE, discard);
    spi_transfer_byte(8'hDD, discard);
    if (partial_bits > 0) shift_bits(8'hCC, partial_bits, discard);
    end_transaction();
endtask

task automatic after_reset_state();
    check_byte("spi_data_out", 8'h00, {7'b0, spi_data_out});
    tx_bytes[0] = 8'h00;
    run_transaction(1);
    check_byte("first byte", 8'h00, rx_bytes[0]);
endtask

task automatic palette_write_read();
    logic [7:0] index_byte;
    for (int k = 0; k < 4; k++) begin
        index_byte = random_byte();
        write_entry(index_byte[3:0], random_byte(), random_byte(), random_byte());
        read_entry(index_byte[3:0]);
    end
endtask

task automatic all_entries();
    for (int i = 0; i < `PALETTE_DEPTH; i++)
        write_entry(4'(i), 8'(16 * i + 1), 8'(16 * i + 2), 8'(16 * i + 3));
    for (int i = `PALETTE_DEPTH - 1; i >= 0; i--) read_entry(4'(i));
endtask

task automatic aborted_write();
    write_entry(4'd5, 8'hA5, 8'h5A, 8'h3C);
    abort_write(4'd5, 4);   // Mid-byte
    read_entry(4'd5);
    abort_write(4'd5, 0);   // Byte boundary
    read_entry(4'd5);
    check_chip_id();
endtask

task automatic unknown_opcode();
    tx_bytes[0] = 8'h5A;
    tx_bytes[1] = 8'h05;
    tx_bytes[2] = 8'h77;
    tx_bytes[3] = 8'h66;
    tx_bytes[4] = 8'h55;
    tx_bytes[5] = 8'h44;
    run_transaction(6);
    for (int i = 0; i < 6; i++) check_byte("unknown opcode response", 8'h00, rx_bytes[i]);
    read_entry(4'd5);
endtask

initial begin
    for (int i = 0; i < `PALETTE_DEPTH; i++) begin
        model_y[i] = 8'h00;
        model_cb[i] = 8'h00;
        model_cr[i] = 8'h00;
    end
    reset <= 1'b1;
    spi_select <= 1'b1;
    spi_clock <= 1'b0;
    spi_data_in <= 1'b0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);

    after_reset_state();
    check_chip_id();
    palette_write_read();
    all_entries();
    aborted_write();
    unknown_opcode();

    error_count += i_dut.spi_peripheral.i_assertions.failure_count;
    $display("Run finished with %0d errors", error_count);
    if (error_count == 0)
        $display("Test OK");
    else
        $display("Test FAILED");
    $finish;
end

endmodule

`default_nettype wire

// File: bench/spi_command_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module spi_command_assertions (
    input logic clock,
    input logic reset,
    input logic spi_select,
    input command_pkg::opcode_e opcode,     // Decoded opcode for the testbench
    input logic opcode_valid,
    input logic operand_valid
);

int failure_count = 0;

valid_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(opcode_valid && operand_valid))
    else begin
        $error("opcode_valid and operand_valid high together");
        failure_count++;
    end

opcode_single_cycle: assert property (@(posedge clock) disable iff (reset)
    opcode_valid |=> !opcode_valid)
    else begin
        $error("opcode_valid lasted more than one cycle");
        failure_count++;
    end

operand_single_cycle: assert property (@(posedge clock) disable iff (reset)
    operand_valid |=> !operand_valid)
    else begin
        $error("operand_valid lasted more than one cycle");
        failure_count++;
    end

// No decode while the host has select raised
quiet_when_deselected: assert property (@(posedge clock) disable iff (reset)
    spi_select |-> !(opcode_valid || operand_valid))
    else begin
        $error("valid pulse while spi_select is high");
        failure_count++;
    end

quiet_after_reset: assert property (@(posedge clock)
    reset |=> !(opcode_valid || operand_valid))
    else begin
        $error("valid pulse in the cycle after reset");
        failure_count++;
    end

endmodule

bind spi_peripheral spi_command_assertions i_assertions (
    .clock(clock),
    .reset(reset),
    .spi_select(spi_select),
    .opcode(opcode),
    .opcode_valid(opcode_valid),
    .operand_valid(operand_valid)
);

`default_nettype wire

// File: verilog/spi_command_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "command_consts.svh"

module spi_command_top (
    input logic clock,
    input logic reset,

    input logic spi_select,
    input logic spi_clock,
    input logic spi_data_in,
    output logic spi_data_out
);

// Decoded command shared by every responder
command_pkg::opcode_e opcode;
logic opcode_valid;
logic [7:0] operand;
logic operand_valid;
logic [`OPERAND_COUNT_BITS-1:0] operand_count;

logic [7:0] chip_response;
logic chip_response_valid;
logic [7:0] palette_response;
logic palette_response_valid;

spi_peripheral spi_peripheral (
    .clock(clock),
    .reset(reset),

    .spi_select(spi_select),
    .spi_clock(spi_clock),
    .spi_data_in(spi_data_in),

    .chip_response(chip_response),
    .chip_response_valid(chip_response_valid),
    .palette_response(palette_response),
    .palette_response_valid(palette_response_valid),

    .spi_data_out(spi_data_out),

    .opcode(opcode),
    .opcode_valid(opcode_valid),
    .operand(operand),
    .operand_valid(operand_valid),
    .operand_count(operand_count)
);

// Chip identifier
spi_register #(
    .REGISTER_ADDRESS(command_pkg::CHIP_ID),
    .REGISTER_VALUE(`CHIP_ID_VALUE)
) chip_id (
    .clock(clock),
    .reset(reset),
    .opcode(opcode),
    .opcode_valid(opcode_valid),
    .response(chip_response),
    .response_valid(chip_response_valid)
);

palette_registers palette_registers (
    .clock(clock),
    .reset(reset),
    .opcode(opcode),
    .opcode_valid(opcode_valid),
    .operand(operand),
    .operand_valid(operand_valid),
    .operand_count(operand_count),
    .response(palette_response),
    .response_valid(palette_response_valid)
);

endmodule

`default_nettype wire

// File: verilog/palette_registers.sv
`timescale 1ns/100ps
`default_nettype none

`include "command_consts.svh"

module palette_registers (
    input logic clock,
    input logic reset,

    input command_pkg::opcode_e opcode,
    input logic opcode_valid,
    input logic [7:0] operand,
    input logic operand_valid,
    input logic [`OPERAND_COUNT_BITS-1:0] operand_count,

    output logic [7:0] response,
    output logic response_valid
);

command_pkg::palette_state_e state;

logic [7:0] palette_y [`PALETTE_DEPTH];
logic [7:0] palette_cb [`PALETTE_DEPTH];
logic [7:0] palette_cr [`PALETTE_DEPTH];

logic [`PALETTE_INDEX_BITS-1:0] entry_index;
logic [7:0] staged_y;
logic [7:0] staged_cb;
logic answer;       // Raise valid on the following cycle

always_ff @(posedge clock) begin
    if (reset) begin
        state <= command_pkg::PALETTE_IDLE;
        answer <= 1'b0;
        response_valid <= 1'b0;
        for (int i = 0; i < `PALETTE_DEPTH; i++) begin
            palette_y[i] <= 8'h00;
            palette_cb[i] <= 8'h00;
            palette_cr[i] <= 8'h00;
        end
    end else begin
        response_valid <= answer;

        if (opcode_valid) begin
            answer <= 1'b0;
            response_valid <= 1'b0;
            case (opcode)
                command_pkg::PALETTE_WRITE: state <= command_pkg::PALETTE_WRITING;
                command_pkg::PALETTE_READ: state <= command_pkg::PALETTE_READING;
                default: state <= command_pkg::PALETTE_IDLE;
            endcase
        end else if (operand_valid) begin
            answer <= 1'b0;
            response_valid <= 1'b0;
            case (state)
                command_pkg::PALETTE_WRITING: begin
                    case (operand_count)
                        'd0: entry_index <= operand[`PALETTE_INDEX_BITS-1:0];
                        'd1: staged_y <= operand;
                        'd2: staged_cb <= operand;
                        'd3: begin  // Commit all three together
                            palette_y[entry_index] <= staged_y;
                            palette_cb[entry_index] <= staged_cb;
                            palette_cr[entry_index] <= operand;
                        end
                        default: ;
                    endcase
                end
                command_pkg::PALETTE_READING: begin
                    case (operand_count)
                        'd0: begin
                            entry_index <= operand[`PALETTE_INDEX_BITS-1:0];
                            response <= palette_y[operand[`PALETTE_INDEX_BITS-1:0]];
                            answer <= 1'b1;
                        end
                        'd1: begin
                            response <= palette_cb[entry_index];
                            answer <= 1'b1;
                        end
                        'd2: begin
                            response <= palette_cr[entry_index];
                            answer <= 1'b1;
                        end
                        default: ;      // Nothing after Cr
                    endcase
                end
                default: ;
            endcase
        end
    end
end

endmodule

`default_nettype wire

// File: verilog/spi_register.sv
`timescale 1ns/100ps
`default_nettype none

module spi_register #(
    parameter command_pkg::opcode_e REGISTER_ADDRESS = command_pkg::CHIP_ID,
    parameter logic [7:0] REGISTER_VALUE = 8'h00
) (
    input logic clock,
    input logic reset,

    input command_pkg::opcode_e opcode,
    input logic opcode_valid,

    output logic [7:0] response,
    output logic response_valid
);

logic address_match;

// Valid drops for a cycle on every opcode and then follows the match
always_ff @(posedge clock) begin
    if (reset) begin
        address_match <= 1'b0;
        response_valid <= 1'b0;
    end else if (opcode_valid) begin
        address_match <= (opcode == REGISTER_ADDRESS);
        response_valid <= 1'b0;
    end else begin
        response_valid <= address_match;
    end
end

always_ff @(posedge clock) begin
    if (opcode_valid && opcode == REGISTER_ADDRESS) response <= REGISTER_VALUE;
end

endmodule

`default_nettype wire

// File: verilog/spi_peripheral.sv
`timescale 1ns/100ps
`default_nettype none

`include "command_consts.svh"

module spi_peripheral (
    input logic clock,
    input logic reset,

    input logic spi_select,
    input logic spi_clock,
    input logic spi_data_in,

    input logic [7:0] chip_response,
    input logic chip_response_valid,
    input logic [7:0] palette_response,
    input logic palette_response_valid,

    output logic spi_data_out,

    output command_pkg::opcode_e opcode,
    output logic opcode_valid,
    output logic [7:0] operand,
    output logic operand_valid,
    output logic [`OPERAND_COUNT_BITS-1:0] operand_count
);

// Pin synchronizers with bit 1 as the stable copy
logic [1:0] select_sync;
logic [1:0] clock_sync;
logic [1:0] data_sync;
logic clock_prev;

logic selected;
logic clock_rise;
logic clock_fall;

always_ff @(posedge clock) begin
    if (reset) begin
        select_sync <= 2'b11;   // Idle means deselected
        clock_sync <= 2'b00;
        data_sync <= 2'b00;
        clock_prev <= 1'b0;
    end else begin
        select_sync <= {select_sync[0], spi_select};
        clock_sync <= {clock_sync[0], spi_clock};
        data_sync <= {data_sync[0], spi_data_in};
        clock_prev <= clock_sync[1];
    end
end

assign selected = ~select_sync[1];
assign clock_rise = clock_sync[1] & ~clock_prev;
assign clock_fall = ~clock_sync[1] & clock_prev;

// Receive side and transaction decode
command_pkg::spi_phase_e phase;
logic [2:0] bit_count;
logic [6:0] rx_shift;
logic [7:0] rx_byte;

assign rx_byte = {rx_shift, data_sync[1]};  // Byte as it stands after this bit

always_ff @(posedge clock) begin
    if (reset || !selected) begin
        phase <= command_pkg::PHASE_IDLE;
        bit_count <= 3'd0;              // Partial byte dropped
        operand_count <= '0;
        opcode_valid <= 1'b0;
        operand_valid <= 1'b0;
    end else begin
        opcode_valid <= 1'b0;
        operand_valid <= 1'b0;

        if (operand_valid) operand_count <= operand_count + 1'b1;

        if (phase == command_pkg::PHASE_IDLE) phase <= command_pkg::PHASE_OPCODE;

        if (clock_rise) begin
            rx_shift <= rx_byte[6:0];
            bit_count <= bit_count + 1'b1;

            if (bit_count == 3'd7) begin
                if (phase == command_pkg::PHASE_OPERAND) begin
                    operand <= rx_byte;
                    operand_valid <= 1'b1;
                end else begin
                    opcode <= command_pkg::opcode_e'(rx_byte);
                    opcode_valid <= 1'b1;
                    phase <= command_pkg::PHASE_OPERAND;
                end
            end
        end
    end
end

// A response counts only when its valid rises after the latest pulse
logic chip_valid_prev;
logic palette_valid_prev;
logic pending_valid;
logic [7:0] pending_response;

always_ff @(posedge clock) begin
    if (reset) begin
        chip_valid_prev <= 1'b0;
        palette_valid_prev <= 1'b0;
    end else begin
        chip_valid_prev <= chip_response_valid;
        palette_valid_prev <= palette_response_valid;
    end
end

always_ff @(posedge clock) begin
    if (reset || !selected || opcode_valid || operand_valid) begin
        pending_valid <= 1'b0;
    end else if (chip_response_valid && !chip_valid_prev) begin
        pending_response <= chip_response;
        pending_valid <= 1'b1;
    end else if (palette_response_valid && !palette_valid_prev) begin
        pending_response <= palette_response;
        pending_valid <= 1'b1;
    end
end

// Transmit shifter sends MSB first on falling edges
logic [7:0] tx_shift;

always_ff @(posedge clock) begin
    if (reset || !selected) begin
        tx_shift <= 8'h00;
    end else if (clock_fall) begin
        if (bit_count == 3'd0) begin
            tx_shift <= pending_valid ? pending_response : 8'h00;  // Next byte starts
        end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end
end

assign spi_data_out = tx_shift[7];

endmodule

`default_nettype wire

// File: verilog/command_pkg.sv
`default_nettype none

package command_pkg;

    // First byte of every SPI transaction
    typedef enum logic [7:0] {
        PALETTE_WRITE = 8'h11,
        PALETTE_READ  = 8'h12,
        CHIP_ID       = 8'hDB
    } opcode_e;

    // Where the peripheral is within a transaction
    typedef enum logic [1:0] {
        PHASE_IDLE,
        PHASE_OPCODE,
        PHASE_OPERAND
    } spi_phase_e;

    typedef enum logic [1:0] {
        PALETTE_IDLE,
        PALETTE_WRITING,
        PALETTE_READING
    } palette_state_e;

endpackage

`default_nettype wire

// File: include/command_consts.svh
`ifndef COMMAND_CONSTS_SVH
`define COMMAND_CONSTS_SVH

// Byte returned by the chip identifier register
`define CHIP_ID_VALUE 8'h81

// Palette geometry
`define PALETTE_DEPTH 16
`define PALETTE_INDEX_BITS 4

// Operand counter width so the count wraps after 255
`define OPERAND_COUNT_BITS 8

`endif
